/* flist.f */
+incdir+src
src/gearbox_pkg.sv
src/pattern_source.sv
src/gearbox_1_to_2.sv
src/display_scan_ctrl.sv
src/seven_seg_encoder.sv
src/gearbox_demo_top.sv
tb/gearbox_demo_assertions.sv
tb/gearbox_demo_tb.sv

/* src/display_scan_ctrl.sv */
`timescale 1ns/1ps
`include "gearbox_defs.svh"

module display_scan_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    up_vld,
    input  gearbox_pkg::narrow_t    up_data,
    input  logic                    down_vld,
    input  gearbox_pkg::wide_t      down_data,
    output gearbox_pkg::digit_sel_t digit,
    output gearbox_pkg::nibble_t    nibble,
    output logic                    dot,
    output logic                    blank
);

    localparam int DIV_W = (`GBX_SCAN_DIV > 1) ? $clog2(`GBX_SCAN_DIV) : 1;

    //----------------------------------------------------------------------
    // Scan FSM and divider

    gearbox_pkg::scan_state_t state;
    logic [DIV_W - 1:0]       div_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= gearbox_pkg::SCAN_IDLE;
            div_cnt <= '0;
            digit   <= '0;
        end else if (state == gearbox_pkg::SCAN_IDLE) begin
            // Light digit 0 on the first cycle out of reset
            state   <= gearbox_pkg::SCAN_RUN;
            div_cnt <= '0;
            digit   <= gearbox_pkg::digit_sel_t'(1);
        end else if (div_cnt == DIV_W'(`GBX_SCAN_DIV - 1)) begin
            div_cnt <= '0;
            digit   <= {digit[`GBX_DIGITS - 2:0], digit[`GBX_DIGITS - 1]};
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // Content of the lit digit

    always_comb begin
        nibble = '0;
        dot    = 1'b0;
        // Nothing lit before the scan starts
        blank  = (state == gearbox_pkg::SCAN_IDLE);

        if (digit[0]) begin
            nibble = down_data[`GBX_WIDTH - 1:0];
            blank  = ~down_vld;
        end else if (digit[1]) begin
            nibble = down_data[2 * `GBX_WIDTH - 1:`GBX_WIDTH];
            blank  = ~down_vld;
        end else if (digit[2]) begin
            blank  = 1'b1;  // separator between the two words
        end else if (digit[3]) begin
            nibble = up_data;
            dot    = up_vld;
        end
    end

endmodule

/* src/gearbox_1_to_2.sv */
`timescale 1ns/1ps

module gearbox_1_to_2 (
    input  logic                 clk,
    input  logic                 rst_n,

    // Narrow side
    input  logic                 up_vld,
    output logic                 up_rdy,
    input  gearbox_pkg::narrow_t up_data,

    // Wide side
    output logic                 down_vld,
    input  logic                 down_rdy,
    output gearbox_pkg::wide_t   down_data
);

    //----------------------------------------------------------------------
    // Occupancy and handshake

    logic                 half_full;
    gearbox_pkg::narrow_t upper_half;
    logic                 accept;

    // Room exists when the output is empty or draining this cycle
    assign up_rdy = ~down_vld | down_rdy;
    assign accept = up_vld & up_rdy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half_full <= 1'b0;
            down_vld  <= 1'b0;
        end else begin
            if (accept) begin
                half_full <= ~half_full;
            end

            // A completing pair wins over a drain on the same edge
            if (accept && half_full) begin
                down_vld <= 1'b1;
            end else if (down_rdy) begin
                down_vld <= 1'b0;
            end
        end
    end

    //----------------------------------------------------------------------
    // Payload

    always_ff @(posedge clk) begin
        // First word of a pair goes to the upper half
        if (accept && !half_full) begin
            upper_half <= up_data;
        end

        if (accept && half_full) begin
            down_data <= {upper_half, up_data};
        end
    end

endmodule

/* src/gearbox_defs.svh */
`ifndef GEARBOX_DEFS_SVH
`define GEARBOX_DEFS_SVH

// Narrow word width, the wide word is twice this
`define GBX_WIDTH     4

// Digits on the multiplexed display
`define GBX_DIGITS    8

// Clock cycles each digit stays lit
// Kept short for simulation, a board build wants thousands
`define GBX_SCAN_DIV  4

`endif

/* src/gearbox_demo_top.sv */
`timescale 1ns/1ps

module gearbox_demo_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Upstream handshake
    input  logic                    up_vld,
    output logic                    up_rdy,
    output gearbox_pkg::narrow_t    up_data,

    // Downstream handshake
    input  logic                    down_rdy,
    output logic                    down_vld,
    output gearbox_pkg::wide_t      down_data,

    // Multiplexed seven-segment display
    output gearbox_pkg::segments_t  abcdefgh,
    output gearbox_pkg::digit_sel_t digit
);

    gearbox_pkg::nibble_t nibble;
    logic                 dot;
    logic                 blank;

    //----------------------------------------------------------------------
    // Data path

    pattern_source i_source (
        .clk     (clk),
        .rst_n   (rst_n),
        .up_vld  (up_vld),
        .up_rdy  (up_rdy),
        .up_data (up_data)
    );

    gearbox_1_to_2 i_gearbox (
        .clk       (clk),
        .rst_n     (rst_n),
        .up_vld    (up_vld),
        .up_rdy    (up_rdy),
        .up_data   (up_data),
        .down_vld  (down_vld),
        .down_rdy  (down_rdy),
        .down_data (down_data)
    );

    //----------------------------------------------------------------------
    // Display

    display_scan_ctrl i_scan (
        .clk       (clk),
        .rst_n     (rst_n),
        .up_vld    (up_vld),
        .up_data   (up_data),
        .down_vld  (down_vld),
        .down_data (down_data),
        .digit     (digit),
        .nibble    (nibble),
        .dot       (dot),
        .blank     (blank)
    );

    seven_seg_encoder i_encoder (
        .nibble   (nibble),
        .dot      (dot),
        .blank    (blank),
        .abcdefgh (abcdefgh)
    );

endmodule

/* src/gearbox_pkg.sv */
`include "gearbox_defs.svh"

package gearbox_pkg;

    //----------------------------------------------------------------------
    // Datapath words

    typedef logic [    `GBX_WIDTH - 1:0] narrow_t;
    typedef logic [2 * `GBX_WIDTH - 1:0] wide_t;

    // Position in the constant pattern table
    typedef logic [3:0] pattern_index_t;

    //----------------------------------------------------------------------
    // Display

    // One hex value per digit
    typedef logic [3:0] nibble_t;

    // abcdefgh, h is the dot, active high
    typedef logic [7:0] segments_t;

    // One-hot digit enable, active high
    typedef logic [`GBX_DIGITS - 1:0] digit_sel_t;

    typedef enum logic {
        SCAN_IDLE,
        SCAN_RUN
    } scan_state_t;

endpackage

/* src/pattern_source.sv */
`timescale 1ns/1ps

module pattern_source (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 up_vld,
    input  logic                 up_rdy,
    output gearbox_pkg::narrow_t up_data
);

    //----------------------------------------------------------------------
    // Constant word sequence

    localparam gearbox_pkg::narrow_t PATTERN [16] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    //----------------------------------------------------------------------
    // Table position

    gearbox_pkg::pattern_index_t index;

    // Advance only on an accepted word, wraps naturally after 15
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index <= '0;
        end else if (up_vld && up_rdy) begin
            index <= index + 1'b1;
        end
    end

    // Word stays put while the gearbox stalls
    always_comb begin
        up_data = PATTERN[index];
    end

endmodule

/* src/seven_seg_encoder.sv */
`timescale 1ns/1ps

module seven_seg_encoder (
    input  gearbox_pkg::nibble_t   nibble,
    input  logic                   dot,
    input  logic                   blank,
    output gearbox_pkg::segments_t abcdefgh
);

    logic [6:0] abcdefg;

    // Standard hex glyphs, segment a in the MSB
    always_comb begin
        case (nibble)
            4'h0:    abcdefg = 7'b1111110;
            4'h1:    abcdefg = 7'b0110000;
            4'h2:    abcdefg = 7'b1101101;
            4'h3:    abcdefg = 7'b1111001;
            4'h4:    abcdefg = 7'b0110011;
            4'h5:    abcdefg = 7'b1011011;
            4'h6:    abcdefg = 7'b1011111;
            4'h7:    abcdefg = 7'b1110000;
            4'h8:    abcdefg = 7'b1111111;
            4'h9:    abcdefg = 7'b1111011;
            4'ha:    abcdefg = 7'b1110111;
            4'hb:    abcdefg = 7'b0011111;
            4'hc:    abcdefg = 7'b1001110;
            4'hd:    abcdefg = 7'b0111101;
            4'he:    abcdefg = 7'b1001111;
            default: abcdefg = 7'b1000111;
        endcase
    end

    // Blank overrides both the glyph and the dot
    always_comb begin
        if (blank) begin
            abcdefgh = '0;
        end else begin
            abcdefgh = {abcdefg, dot};
        end
    end

endmodule

/* tb/gearbox_demo_assertions.sv */
`timescale 1ns/1ps

module gearbox_demo_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    up_vld,
    input logic                    up_rdy,
    input gearbox_pkg::narrow_t    up_data,
    input logic                    down_vld,
    input logic                    down_rdy,
    input gearbox_pkg::wide_t      down_data,
    input gearbox_pkg::digit_sel_t digit
);

    // Number of assertion failures so far
    int unsigned failures = 0;

    //----------------------------------------------------------------------
    // Word counts seen on both handshakes

    int unsigned accepted;
    int unsigned drained;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accepted <= 0;
            drained  <= 0;
        end else begin
            if (up_vld && up_rdy) begin
                accepted <= accepted + 1;
            end
            if (down_vld && down_rdy) begin
                drained <= drained + 1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Handshake payloads hold while stalled

    a_up_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        (up_vld && !up_rdy) |=> $stable(up_data))
        else begin
            failures++;
            $error("up_data changed while the upstream word was stalled");
        end

    a_down_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        (down_vld && !down_rdy) |=> $stable(down_data))
        else begin
            failures++;
            $error("down_data changed while the wide word was stalled");
        end

    //----------------------------------------------------------------------
    // Gearbox occupancy and display select

    // Full while a packed word still waits downstream
    a_up_rdy_rule: assert property (@(posedge clk) disable iff (!rst_n)
        up_rdy == ((accepted / 2 == drained) || down_rdy))
        else begin
            failures++;
            $error("up_rdy does not follow the output occupancy");
        end

    a_digit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(digit))
        else begin
            failures++;
            $error("digit select has more than one digit lit");
        end

endmodule

bind gearbox_demo_top gearbox_demo_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .up_vld    (up_vld),
    .up_rdy    (up_rdy),
    .up_data   (up_data),
    .down_vld  (down_vld),
    .down_rdy  (down_rdy),
    .down_data (down_data),
    .digit     (digit)
);

/* tb/gearbox_demo_tb.sv */
`timescale 1ns/1ps
`include "gearbox_defs.svh"

module gearbox_demo_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int TRANSFERS    = 80;
    localparam int STALL_CYCLES = 12;
    localparam int SCAN_CYCLES  = 2 * `GBX_SCAN_DIV * `GBX_DIGITS;
    localparam int TIMEOUT_NS   = (TRANSFERS * 4 + SCAN_CYCLES + 100) * CLK_PERIOD;

    logic                    clk;
    logic                    rst_n;
    logic                    up_vld;
    logic                    up_rdy;
    gearbox_pkg::narrow_t    up_data;
    logic                    down_vld;
    logic                    down_rdy;
    gearbox_pkg::wide_t      down_data;
    gearbox_pkg::segments_t  abcdefgh;
    gearbox_pkg::digit_sel_t digit;

    // Model state updated on rising edges
    int                      errors = 0;
    int                      checks = 0;
    int                      xfers = 0;
    int                      stall_start;
    int                      lit_idx = -1;
    int                      run_len = 0;
    logic                    have_half = 1'b0;
    gearbox_pkg::narrow_t    half_word;
    gearbox_pkg::wide_t      pair_q[$];
    gearbox_pkg::digit_sel_t seen_digits = '0;

    gearbox_demo_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .up_vld    (up_vld),
        .up_rdy    (up_rdy),
        .up_data   (up_data),
        .down_rdy  (down_rdy),
        .down_vld  (down_vld),
        .down_data (down_data),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //----------------------------------------------------------------------
    // Reference model

    // Word the source should present after n transfers
    function automatic gearbox_pkg::narrow_t table_word(input int n);
        case (n % 16)
            0: table_word = 4'h2;
            1: table_word = 4'h6;
            2: table_word = 4'hd;
            3: table_word = 4'hb;
            4: table_word = 4'h7;
            5: table_word = 4'he;
            6: table_word = 4'hc;
            7: table_word = 4'h4;
            8: table_word = 4'h1;
            9: table_word = 4'h0;
            10: table_word = 4'h9;
            11: table_word = 4'ha;
            12: table_word = 4'hf;
            13: table_word = 4'h5;
            14: table_word = 4'h8;
            default: table_word = 4'h3;
        endcase
    endfunction

    // Segments a to g with a in the MSB
    function automatic logic [6:0] hex_glyph(input gearbox_pkg::nibble_t value);
        logic [6:0] glyphs [16];
        glyphs = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
                   7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47};
        hex_glyph = glyphs[value];
    endfunction

    function automatic gearbox_pkg::segments_t expected_segments(
        input int idx, input logic vld_up, input gearbox_pkg::narrow_t word_up,
        input logic vld_down, input gearbox_pkg::wide_t word_down);
        case (idx)
            0: expected_segments = vld_down ? {hex_glyph(word_down[3:0]), 1'b0} : 8'h00;
            1: expected_segments = vld_down ? {hex_glyph(word_down[7:4]), 1'b0} : 8'h00;
            2: expected_segments = 8'h00;
            3: expected_segments = {hex_glyph(word_up), vld_up};
            default: expected_segments = {hex_glyph(4'h0), 1'b0};
        endcase
    endfunction

    // Index of the lit digit or -1 when dark
    function automatic int lit_digit(input gearbox_pkg::digit_sel_t sel);
        lit_digit = -1;
        for (int i = 0; i < `GBX_DIGITS; i++) begin
            if (sel[i]) begin
                lit_digit = i;
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
        end
    endtask

    //----------------------------------------------------------------------
    // Compare process

    always @(posedge clk) begin
        int                 idx;
        logic               exp_vld;
        gearbox_pkg::wide_t exp_word;
        gearbox_pkg::wide_t exp_pair;
        if (rst_n) begin
            // Outputs expected from the model state before this edge
            exp_vld  = pair_q.size() != 0;
            exp_word = exp_vld ? pair_q[0] : '0;
            check_value("down_vld", exp_vld, down_vld);
            check_value("up_rdy", !exp_vld || down_rdy, up_rdy);
            check_value("up_data", table_word(xfers), up_data);

            idx = lit_digit(digit);
            check_value("abcdefgh",
                        idx < 0 ? 8'h00 : expected_segments(idx, up_vld, table_word(xfers),
                                                            exp_vld, exp_word),
                        abcdefgh);

            // Drain before fill since the visible wide word is the older pair
            if (down_vld && down_rdy) begin
                if (pair_q.size() == 0) begin
                    errors++;
                    $display("Downstream transfer at %0t with no pair pending", $time);
                end else begin
                    exp_pair = pair_q.pop_front();
                    check_value("down_data", exp_pair, down_data);
                end
            end
            if (up_vld && up_rdy) begin
                if (have_half) begin
                    pair_q.push_back({half_word, table_word(xfers)});
                end else begin
                    half_word = table_word(xfers);
                end
                have_half = ~have_half;
                xfers++;
            end

            // Scan order and dwell time
            if (idx != lit_idx) begin
                if (lit_idx >= 0) begin
                    check_value("digit_dwell", `GBX_SCAN_DIV, run_len);
                    check_value("digit_index", (lit_idx + 1) % `GBX_DIGITS, idx);
                end else begin
                    check_value("first_digit", 0, idx);
                end
                lit_idx = idx;
                run_len = 1;
            end else begin
                run_len++;
            end
            if (idx >= 0) begin
                seen_digits[idx] = 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Stimulus

    task automatic run_random_traffic(input int vld_pct, input int rdy_pct,
                                      input int target);
        while (xfers < target) begin
            up_vld   = ($urandom % 100) < vld_pct;
            down_rdy = ($urandom % 100) < rdy_pct;
            @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(42));
        up_vld   = 1'b0;
        down_rdy = 1'b0;
        rst_n    = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Mostly flowing traffic
        run_random_traffic(70, 70, TRANSFERS / 2);

        // Downstream stall lets at most three words in
        stall_start = xfers;
        up_vld      = 1'b1;
        down_rdy    = 1'b0;
        repeat (STALL_CYCLES) @(negedge clk);
        if (xfers - stall_start > 3) begin
            errors++;
            $display("Gearbox took %0d words while downstream was stalled",
                     xfers - stall_start);
        end
        check_value("up_rdy", 0, up_rdy);

        // Heavy back-pressure
        run_random_traffic(60, 35, TRANSFERS);

        // Empty the output and let the scan run a couple of rounds
        up_vld   = 1'b0;
        down_rdy = 1'b1;
        while (down_vld) @(negedge clk);
        check_value("pairs_pending", 0, pair_q.size());
        repeat (SCAN_CYCLES) @(negedge clk);
        check_value("digits_seen", {`GBX_DIGITS{1'b1}}, seen_digits);

        errors += DUT.u_assertions.failures;
        $display("Errors: %0d in %0d checks over %0d transfers", errors, checks, xfers);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns with %0d transfers done", TIMEOUT_NS, xfers);
        $display("Errors: %0d in %0d checks over %0d transfers", errors, checks, xfers);
        $display("TEST FAILED");
        $finish;
    end

endmodule
